// File: mem_map_pkg.sv
package mem_map_pkg;

	localparam int MEM_SIZE   = 16;
	localparam int DATA_WIDTH = 16;
	localparam int ID_WIDTH   = $clog2(MEM_SIZE);
	localparam int ADDR_WIDTH = 8;
	localparam int BIG_WIDTH  = 2 * DATA_WIDTH;

	typedef logic [DATA_WIDTH-1:0] reg_data_t;
	typedef logic [ID_WIDTH-1:0]   reg_id_t;
	typedef logic [ADDR_WIDTH-1:0] axi_addr_t;
	typedef logic [BIG_WIDTH-1:0]  big_reg_t;

	// Word ids.
	localparam reg_id_t VERSION_ID       = 4'd0;
	localparam reg_id_t MEM_SIZE_ID      = 4'd1;
	localparam reg_id_t MAX_BURST_ID     = 4'd2;
	localparam reg_id_t BURST_SIZE_ID    = 4'd3;
	localparam reg_id_t SCALE_ID         = 4'd4;
	localparam reg_id_t BIG_LO_ID        = 4'd5;
	localparam reg_id_t BIG_HI_ID        = 4'd6;
	localparam reg_id_t BIG_VALID_ID     = 4'd7;
	localparam reg_id_t FIRST_GENERAL_ID = 4'd8;

	localparam reg_data_t FIRMWARE_VERSION = 16'h0102;
	localparam reg_data_t MAX_BURST_SIZE   = 16'd50;
	localparam reg_data_t MAX_SCALE_FACTOR = 16'd15;
	localparam reg_data_t GENERAL_RESET    = '1;

	// First byte address past the map.
	localparam axi_addr_t ADDR_LIMIT = axi_addr_t'(MEM_SIZE * 4);

	function automatic logic addr_valid(axi_addr_t addr);
		return (addr[1:0] == 2'b00) && (addr < ADDR_LIMIT);
	endfunction

	function automatic reg_id_t addr_to_id(axi_addr_t addr);
		return addr[ID_WIDTH+1:2];
	endfunction

	function automatic reg_data_t word_reset(reg_id_t id);
		reg_data_t value;
		case (id)
			VERSION_ID:   value = FIRMWARE_VERSION;
			MEM_SIZE_ID:  value = reg_data_t'(MEM_SIZE);
			MAX_BURST_ID: value = MAX_BURST_SIZE;
			default:      value = (id >= FIRST_GENERAL_ID) ? GENERAL_RESET : '0;
		endcase
		return value;
	endfunction

endpackage

// File: axi_chan_pkg.sv
package axi_chan_pkg;

	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'd0;
	localparam axi_resp_t RESP_SLVERR = 2'd2;

	typedef struct packed {
		logic                  valid;
		mem_map_pkg::axi_addr_t addr;
	} addr_beat_t;

	typedef struct packed {
		logic                  valid;
		mem_map_pkg::reg_data_t data;
	} wdata_beat_t;

	typedef struct packed {
		logic      valid;
		axi_resp_t resp;
	} wresp_beat_t;

	typedef struct packed {
		logic                  valid;
		mem_map_pkg::reg_data_t data;
		axi_resp_t             resp;
	} rdata_beat_t;

	// Single-cycle write into the register bank.
	typedef struct packed {
		logic                  strobe;
		mem_map_pkg::reg_id_t   id;
		mem_map_pkg::reg_data_t data;
	} reg_wr_t;

	typedef enum logic {
		COLLECT,
		RESPOND
	} wr_state_t;

endpackage

// File: axi_write_ctrl.sv
module axi_write_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  axi_chan_pkg::addr_beat_t  wa,
	output logic                      wa_ready,
	input  axi_chan_pkg::wdata_beat_t wd,
	output logic                      wd_ready,
	output axi_chan_pkg::wresp_beat_t wr,
	input  logic                      wr_ready,
	output axi_chan_pkg::reg_wr_t     reg_wr
);
	import mem_map_pkg::*;
	import axi_chan_pkg::*;

	wr_state_t state;
	logic      addr_held;
	logic      data_held;
	axi_addr_t addr_slot;
	reg_data_t data_slot;
	logic      wa_fire;
	logic      wd_fire;
	logic      both_held;
	logic      slot_ok;

	// Each slot accepts one beat, in any order.
	assign wa_ready = (state == COLLECT) && !addr_held;
	assign wd_ready = (state == COLLECT) && !data_held;
	assign wa_fire = wa.valid && wa_ready;
	assign wd_fire = wd.valid && wd_ready;

	assign both_held = (state == COLLECT) && addr_held && data_held;
	assign slot_ok = addr_valid(addr_slot);

	// Bank write lands on the same edge that raises the response.
	assign reg_wr = '{
		strobe: both_held && slot_ok,
		id:     addr_to_id(addr_slot),
		data:   data_slot
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= COLLECT;
			addr_held <= 1'b0;
			data_held <= 1'b0;
			wr <= '0;
		end else begin
			case (state)
				COLLECT: begin
					if (wa_fire) begin
						addr_held <= 1'b1;
					end
					if (wd_fire) begin
						data_held <= 1'b1;
					end
					if (both_held) begin
						state <= RESPOND;
						wr.valid <= 1'b1;
						wr.resp <= slot_ok ? RESP_OKAY : RESP_SLVERR;
					end
				end
				RESPOND: begin
					// Slots free up only once the response is taken.
					if (wr_ready) begin
						state <= COLLECT;
						addr_held <= 1'b0;
						data_held <= 1'b0;
						wr.valid <= 1'b0;
					end
				end
				default: state <= COLLECT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wa_fire) begin
			addr_slot <= wa.addr;
		end
		if (wd_fire) begin
			data_slot <= wd.data;
		end
	end

endmodule

// File: axi_read_ctrl.sv
module axi_read_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  axi_chan_pkg::addr_beat_t  ra,
	output logic                      ra_ready,
	output axi_chan_pkg::rdata_beat_t rd,
	input  logic                      rd_ready,
	output mem_map_pkg::reg_id_t      rd_id,
	input  mem_map_pkg::reg_data_t    rd_value
);
	import mem_map_pkg::*;
	import axi_chan_pkg::*;

	logic      rd_valid;
	reg_data_t rd_data;
	axi_resp_t rd_resp;
	logic      ra_fire;
	logic      ra_ok;

	// One read in flight at a time.
	assign ra_ready = !rd_valid;
	assign ra_fire = ra.valid && ra_ready;
	assign ra_ok = addr_valid(ra.addr);

	// Bank lookup is combinational on the incoming address.
	assign rd_id = addr_to_id(ra.addr);

	assign rd = '{valid: rd_valid, data: rd_data, resp: rd_resp};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else if (ra_fire) begin
			rd_valid <= 1'b1;
		end else if (rd_ready) begin
			rd_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ra_fire) begin
			if (ra_ok) begin
				rd_data <= rd_value;
				rd_resp <= RESP_OKAY;
			end else begin
				rd_data <= '0;
				rd_resp <= RESP_SLVERR;
			end
		end
	end

endmodule

// File: reg_bank.sv
module reg_bank (
	input  logic                                               clk,
	input  logic                                               rst_n,
	input  axi_chan_pkg::reg_wr_t                              reg_wr,
	input  mem_map_pkg::reg_id_t                               rd_id,
	output mem_map_pkg::reg_data_t                             rd_value,
	input  logic [mem_map_pkg::MEM_SIZE-1:0]                   rtl_write_reqs,
	input  mem_map_pkg::reg_data_t [mem_map_pkg::MEM_SIZE-1:0] rtl_wd_in,
	input  logic [mem_map_pkg::MEM_SIZE-1:0]                   rtl_read_reqs,
	input  logic                                               clr_rd_out,
	output mem_map_pkg::reg_data_t [mem_map_pkg::MEM_SIZE-1:0] rtl_rd_out,
	output logic [mem_map_pkg::MEM_SIZE-1:0]                   fresh_bits,
	output mem_map_pkg::big_reg_t                              big_reg,
	output logic                                               big_reg_valid
);
	import mem_map_pkg::*;

	reg_data_t [MEM_SIZE-1:0] words;
	logic [MEM_SIZE-1:0]      cpu_hit;
	logic                     cpu_publish;

	// Version, size and max burst never take writes.
	function automatic logic is_read_only(reg_id_t id);
		return id < BURST_SIZE_ID;
	endfunction

	function automatic reg_data_t limit_write(reg_id_t id, reg_data_t data);
		reg_data_t value;
		value = data;
		if (id == BURST_SIZE_ID && data > MAX_BURST_SIZE) begin
			value = MAX_BURST_SIZE;
		end
		if (id == SCALE_ID && data > MAX_SCALE_FACTOR) begin
			value = MAX_SCALE_FACTOR;
		end
		return value;
	endfunction

	always_comb begin
		cpu_hit = '0;
		if (reg_wr.strobe) begin
			cpu_hit[reg_wr.id] = 1'b1;
		end
	end

	assign cpu_publish = cpu_hit[BIG_VALID_ID];

	assign rd_value = words[rd_id];

	// Local strobe has priority over a processor write to the same word.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_SIZE; i++) begin
				words[i] <= word_reset(reg_id_t'(i));
			end
		end else begin
			for (int i = 0; i < MEM_SIZE; i++) begin
				if (!is_read_only(reg_id_t'(i))) begin
					if (rtl_write_reqs[i]) begin
						words[i] <= limit_write(reg_id_t'(i), rtl_wd_in[i]);
					end else if (cpu_hit[i]) begin
						// Processor write to the valid word only triggers the publish.
						if (reg_id_t'(i) == BIG_VALID_ID) begin
							words[i] <= '0;
						end else begin
							words[i] <= limit_write(reg_id_t'(i), reg_wr.data);
						end
					end
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			big_reg_valid <= 1'b0;
		end else begin
			big_reg_valid <= cpu_publish;
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_publish) begin
			big_reg <= {words[BIG_HI_ID], words[BIG_LO_ID]};
		end
	end

	// Snapshot for the local side, with a fresh bit per word.
	always_ff @(posedge clk) begin
		for (int i = 0; i < MEM_SIZE; i++) begin
			if (rtl_read_reqs[i]) begin
				rtl_rd_out[i] <= words[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fresh_bits <= '0;
		end else begin
			for (int i = 0; i < MEM_SIZE; i++) begin
				if (rtl_read_reqs[i]) begin
					fresh_bits[i] <= 1'b1;
				end else if (clr_rd_out) begin
					fresh_bits[i] <= 1'b0;
				end
			end
		end
	end

endmodule

// File: axi_reg_slave.sv
module axi_reg_slave (
	input  logic                                               clk,
	input  logic                                               rst_n,
	input  axi_chan_pkg::addr_beat_t                           wa,
	output logic                                               wa_ready,
	input  axi_chan_pkg::wdata_beat_t                          wd,
	output logic                                               wd_ready,
	output axi_chan_pkg::wresp_beat_t                          wr,
	input  logic                                               wr_ready,
	input  axi_chan_pkg::addr_beat_t                           ra,
	output logic                                               ra_ready,
	output axi_chan_pkg::rdata_beat_t                          rd,
	input  logic                                               rd_ready,
	input  logic [mem_map_pkg::MEM_SIZE-1:0]                   rtl_write_reqs,
	input  mem_map_pkg::reg_data_t [mem_map_pkg::MEM_SIZE-1:0] rtl_wd_in,
	input  logic [mem_map_pkg::MEM_SIZE-1:0]                   rtl_read_reqs,
	input  logic                                               clr_rd_out,
	output mem_map_pkg::reg_data_t [mem_map_pkg::MEM_SIZE-1:0] rtl_rd_out,
	output logic [mem_map_pkg::MEM_SIZE-1:0]                   fresh_bits,
	output mem_map_pkg::big_reg_t                              big_reg,
	output logic                                               big_reg_valid
);
	import mem_map_pkg::*;
	import axi_chan_pkg::*;

	reg_wr_t   reg_wr;
	reg_id_t   rd_id;
	reg_data_t rd_value;

	axi_write_ctrl u_axi_write_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.wa       (wa),
		.wa_ready (wa_ready),
		.wd       (wd),
		.wd_ready (wd_ready),
		.wr       (wr),
		.wr_ready (wr_ready),
		.reg_wr   (reg_wr)
	);

	axi_read_ctrl u_axi_read_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.ra       (ra),
		.ra_ready (ra_ready),
		.rd       (rd),
		.rd_ready (rd_ready),
		.rd_id    (rd_id),
		.rd_value (rd_value)
	);

	reg_bank u_reg_bank (
		.clk            (clk),
		.rst_n          (rst_n),
		.reg_wr         (reg_wr),
		.rd_id          (rd_id),
		.rd_value       (rd_value),
		.rtl_write_reqs (rtl_write_reqs),
		.rtl_wd_in      (rtl_wd_in),
		.rtl_read_reqs  (rtl_read_reqs),
		.clr_rd_out     (clr_rd_out),
		.rtl_rd_out     (rtl_rd_out),
		.fresh_bits     (fresh_bits),
		.big_reg        (big_reg),
		.big_reg_valid  (big_reg_valid)
	);

endmodule

// File: reg_slave_asserts.sv
module reg_slave_asserts (
	input logic                      clk,
	input logic                      rst_n,
	input axi_chan_pkg::addr_beat_t  wa,
	input logic                      wa_ready,
	input axi_chan_pkg::wdata_beat_t wd,
	input logic                      wd_ready,
	input axi_chan_pkg::wresp_beat_t wr,
	input logic                      wr_ready,
	input axi_chan_pkg::addr_beat_t  ra,
	input logic                      ra_ready,
	input axi_chan_pkg::rdata_beat_t rd,
	input logic                      rd_ready,
	input logic                      big_reg_valid
);

	// Number of failed properties so far.
	int failures = 0;

	// A stalled beat keeps valid high and its payload steady.
	wa_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wa.valid && !wa_ready |=> wa.valid && $stable(wa.addr))
		else begin
			failures++;
			$error("Write address beat changed while stalled.");
		end

	wd_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wd.valid && !wd_ready |=> wd.valid && $stable(wd.data))
		else begin
			failures++;
			$error("Write data beat changed while stalled.");
		end

	wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wr.valid && !wr_ready |=> wr.valid && $stable(wr.resp))
		else begin
			failures++;
			$error("Write response beat changed while stalled.");
		end

	ra_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ra.valid && !ra_ready |=> ra.valid && $stable(ra.addr))
		else begin
			failures++;
			$error("Read address beat changed while stalled.");
		end

	rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rd.valid && !rd_ready |=> rd.valid && $stable({rd.data, rd.resp}))
		else begin
			failures++;
			$error("Read data beat changed while stalled.");
		end

	publish_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		big_reg_valid |=> !big_reg_valid)
		else begin
			failures++;
			$error("big_reg_valid stayed high for two cycles.");
		end

	// No new write is taken while a response is pending.
	ready_while_resp: assert property (@(posedge clk) disable iff (!rst_n)
		wr.valid |-> !wa_ready && !wd_ready)
		else begin
			failures++;
			$error("Write channel ready while a response is pending.");
		end

endmodule

// File: reg_slave_tb.sv
module reg_slave_tb;
	import mem_map_pkg::*;
	import axi_chan_pkg::*;

	localparam int          TIMEOUT_CYCLES = 200;
	localparam logic [31:0] SEED           = 32'heca521ad;

	logic                     clk;
	logic                     rst_n;
	addr_beat_t               wa;
	logic                     wa_ready;
	wdata_beat_t              wd;
	logic                     wd_ready;
	wresp_beat_t              wr;
	logic                     wr_ready;
	addr_beat_t               ra;
	logic                     ra_ready;
	rdata_beat_t              rd;
	logic                     rd_ready;
	logic [MEM_SIZE-1:0]      rtl_write_reqs;
	reg_data_t [MEM_SIZE-1:0] rtl_wd_in;
	logic [MEM_SIZE-1:0]      rtl_read_reqs;
	logic                     clr_rd_out;
	reg_data_t [MEM_SIZE-1:0] rtl_rd_out;
	logic [MEM_SIZE-1:0]      fresh_bits;
	big_reg_t                 big_reg;
	logic                     big_reg_valid;

	int       publish_count;
	big_reg_t published;

	axi_reg_slave u_axi_reg_slave (.*);

	bind axi_reg_slave reg_slave_asserts u_reg_slave_asserts (
		.clk           (clk),
		.rst_n         (rst_n),
		.wa            (wa),
		.wa_ready      (wa_ready),
		.wd            (wd),
		.wd_ready      (wd_ready),
		.wr            (wr),
		.wr_ready      (wr_ready),
		.ra            (ra),
		.ra_ready      (ra_ready),
		.rd            (rd),
		.rd_ready      (rd_ready),
		.big_reg_valid (big_reg_valid)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Random back-pressure on both response channels.
	initial begin
		void'($urandom(SEED));
		forever begin
			@(posedge clk);
			#1;
			if (rst_n) begin
				wr_ready = ($urandom_range(3, 0) != 0);
				rd_ready = ($urandom_range(3, 0) != 0);
			end
		end
	end

	// The pulse spans a whole cycle, so the falling edge sees it once.
	always @(negedge clk) begin
		if (rst_n && big_reg_valid) begin
			publish_count++;
			published = big_reg;
		end
	end

	always @(u_axi_reg_slave.u_reg_slave_asserts.failures) begin
		if (u_axi_reg_slave.u_reg_slave_asserts.failures != 0) begin
			abort_run("A handshake assertion on the slave failed.");
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped.");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, expected));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic count_wait(inout int cycles, input string what);
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			abort_run({"Timed out waiting for ", what, "."});
		end
	endtask

	// Order A sends the address first, D the data first, T both together.
	task automatic processor_write(input logic [7:0] order, input axi_addr_t addr,
			input reg_data_t data, input axi_resp_t exp_resp);
		int        cycles;
		logic      a_fire;
		logic      d_fire;
		bit        done;
		axi_resp_t resp;
		cycles = 0;
		done = 1'b0;
		resp = '0;
		wa.addr = addr;
		wd.data = data;
		wa.valid = (order != "D");
		wd.valid = (order != "A");
		while (wa.valid || wd.valid) begin
			@(negedge clk);
			a_fire = wa.valid && wa_ready;
			d_fire = wd.valid && wd_ready;
			next_cycle();
			if (a_fire) begin
				wa.valid = 1'b0;
				wd.valid = wd.valid || (order == "A");
			end
			if (d_fire) begin
				wd.valid = 1'b0;
				wa.valid = wa.valid || (order == "D");
			end
			count_wait(cycles, "the write address and data to be accepted");
		end
		cycles = 0;
		while (!done) begin
			@(negedge clk);
			if (wr.valid && wr_ready) begin
				done = 1'b1;
				resp = wr.resp;
			end
			next_cycle();
			count_wait(cycles, "the write response");
		end
		check_value("wr.resp", 32'(resp), 32'(exp_resp));
	endtask

	task automatic processor_read(input axi_addr_t addr, input reg_data_t exp_data,
			input axi_resp_t exp_resp);
		int          cycles;
		bit          done;
		rdata_beat_t beat;
		cycles = 0;
		done = 1'b0;
		beat = '0;
		ra.addr = addr;
		ra.valid = 1'b1;
		while (!done) begin
			@(negedge clk);
			done = ra_ready;
			next_cycle();
			count_wait(cycles, "the read address to be accepted");
		end
		ra.valid = 1'b0;
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (rd.valid && rd_ready) begin
				done = 1'b1;
				beat = rd;
			end
			next_cycle();
			count_wait(cycles, "the read data");
		end
		check_value("rd.data", 32'(beat.data), 32'(exp_data));
		check_value("rd.resp", 32'(beat.resp), 32'(exp_resp));
	endtask

	task automatic local_write(input reg_id_t id, input reg_data_t data);
		rtl_wd_in[id] = data;
		rtl_write_reqs[id] = 1'b1;
		next_cycle();
		rtl_write_reqs = '0;
	endtask

	task automatic local_read(input reg_id_t id, input reg_data_t exp_data);
		rtl_read_reqs[id] = 1'b1;
		next_cycle();
		rtl_read_reqs = '0;
		check_value($sformatf("rtl_rd_out[%0d]", id), 32'(rtl_rd_out[id]), 32'(exp_data));
		check_value($sformatf("fresh_bits[%0d]", id), 32'(fresh_bits[id]), 32'd1);
	endtask

	task automatic clear_fresh(input logic [MEM_SIZE-1:0] exp_bits);
		clr_rd_out = 1'b1;
		next_cycle();
		clr_rd_out = 1'b0;
		check_value("fresh_bits", 32'(fresh_bits), 32'(exp_bits));
	endtask

	initial begin
		int          fd;
		int          fields;
		int          ops;
		string       line;
		logic [15:0] op;
		logic [7:0]  order;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expected;
		logic [31:0] resp;
		publish_count = 0;
		published = '0;
		ops = 0;
		rst_n = 1'b0;
		wa = '0;
		wd = '0;
		ra = '0;
		wr_ready = 1'b0;
		rd_ready = 1'b0;
		rtl_write_reqs = '0;
		rtl_wd_in = '0;
		rtl_read_reqs = '0;
		clr_rd_out = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value("ready signals", 32'({wa_ready, wd_ready, ra_ready}), 32'h7);
		check_value("valid signals", 32'({wr.valid, rd.valid, big_reg_valid}), 32'h0);
		check_value("fresh_bits", 32'(fresh_bits), 32'h0);
		fd = $fopen("reg_slave_input.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open reg_slave_input.txt.");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			fields = $sscanf(line, "%s %s %h %h %h %h", op, order, addr, data, expected, resp);
			if (fields != 6) begin
				abort_run({"Malformed line in the data file: ", line});
			end
			ops++;
			case (op)
				"PW": processor_write(order, axi_addr_t'(addr), reg_data_t'(data),
					axi_resp_t'(resp));
				"PR": processor_read(axi_addr_t'(addr), reg_data_t'(expected), axi_resp_t'(resp));
				"LW": local_write(reg_id_t'(addr), reg_data_t'(data));
				"LR": local_read(reg_id_t'(addr), reg_data_t'(expected));
				"CL": clear_fresh(MEM_SIZE'(expected));
				"BV": begin
					check_value("big_reg_valid pulses", 32'(publish_count), 32'd1);
					check_value("big_reg", published, expected);
					publish_count = 0;
				end
				default: abort_run({"Unknown operation in the data file: ", line});
			endcase
		end
		$fclose(fd);
		if (ops > 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abort_run("No operations were run from the data file.");
		end
	end

endmodule

// File: reg_slave_input.txt
# op order addr_or_id data expected resp, numbers in hex; order A/D/T = addr first, data first, both
# PW/PR take a byte address, LW/LR take a word id, CL expects fresh bits, BV the 32-bit big register
LR - 0 0 0102 0
LR - 1 0 0010 0
LR - 2 0 0032 0
LR - 3 0 0000 0
LR - 4 0 0000 0
LR - 5 0 0000 0
LR - 6 0 0000 0
LR - 7 0 0000 0
LR - 8 0 ffff 0
LR - 9 0 ffff 0
LR - a 0 ffff 0
LR - b 0 ffff 0
LR - c 0 ffff 0
LR - d 0 ffff 0
LR - e 0 ffff 0
LR - f 0 ffff 0
PW A 20 1234 0 0
PW D 24 5678 0 0
PW T 3c abcd 0 0
PR - 20 0 1234 0
PR - 24 0 5678 0
PR - 3c 0 abcd 0
PW T 0c 0064 0 0
PR - 0c 0 0032 0
PW A 10 0020 0 0
PR - 10 0 000f 0
PW D 10 0007 0 0
PR - 10 0 0007 0
PW D 00 ffff 0 0
PR - 00 0 0102 0
PW A 04 0000 0 0
PR - 04 0 0010 0
PW T 14 beef 0 0
PW A 18 cafe 0 0
PW D 1c 0001 0 0
BV - 0 0 cafebeef 0
PR - 1c 0 0000 0
PW T 22 1111 0 2
PW A 40 2222 0 2
PR - 21 0 0000 2
PR - 80 0 0000 2
LW - 9 5a5a 0 0
PR - 24 0 5a5a 0
CL - 0 0 0000 0
LR - 9 0 5a5a 0

// File: filelist.f
mem_map_pkg.sv
axi_chan_pkg.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
reg_bank.sv
axi_reg_slave.sv
reg_slave_asserts.sv
reg_slave_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= reg_slave_tb
RTL_TOP   ?= axi_reg_slave
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
